// File: rtl/rvCore_defs.svh
////////////////////////////////////////////////////////////
// global sizes and constants of the RV32I core
// data width, reset PC, register count and bubble encoding
////////////////////////////////////////////////////////////

`ifndef RVCORE_DEFS_SVH
`define RVCORE_DEFS_SVH

// data and address width
`define XLEN 32

// first fetch address after reset
`define PcReset 32'h0000_0000

// architectural integer registers
`define RegCount 32

// addi x0, x0, 0 marks a bubble
`define NopInstr 32'h0000_0013

`endif

// File: rtl/rvPkg.sv
////////////////////////////////////////////////////////////
// shared types of the RV32I core
// instruction views, ALU ops and pipeline records
////////////////////////////////////////////////////////////

`default_nettype none

`include "rvCore_defs.svh"

package rvPkg;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } rTypeT;

  typedef struct packed {
    logic [11:0] imm12;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } iTypeT;

  // one instruction word, read as R or I format
  typedef union packed {
    rTypeT rType;
    iTypeT iType;
  } instrU;

  typedef enum logic [2:0] {
    AluAdd,
    AluSub,
    AluAnd,
    AluOr,
    AluXor,
    AluSlt,
    AluPassB,
    AluCmpEq
  } aluOpE;

  typedef struct packed {
    aluOpE aluOp;
    logic  useImm;
    logic  regWen;
    logic  isBranch;
    logic  branchNe;
    logic  isJal;
    logic  isLui;
    logic  illegal;
    logic  isEbreak;
  } ctrlT;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    instrU             instr;
  } ifIdT;

  // rs1/rs2 ride along so execute can match them for forwarding
  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    ctrlT              ctrl;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [`XLEN-1:0]  rs1Data;
    logic [`XLEN-1:0]  rs2Data;
    logic [`XLEN-1:0]  imm;
  } idExT;

  typedef struct packed {
    logic              valid;
    logic [`XLEN-1:0]  pc;
    logic [4:0]        rd;
    logic [`XLEN-1:0]  wdata;
    logic              wen;
    logic              illegal;
  } retireT;

  typedef struct packed {
    logic              taken;
    logic [`XLEN-1:0]  target;
  } redirectT;

endpackage

`default_nettype wire

// File: rtl/fetchStage.sv
////////////////////////////////////////////////////////////
// fetch stage
// PC register, next-PC select, halt flag, IF/ID register
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defs.svh"

module fetchStage
  import rvPkg::*;
(
  input  wire logic             clk,
  input  wire logic             arstN,
  input  wire logic [`XLEN-1:0] imemData,
  input  wire redirectT         redirect,
  input  wire logic             haltReq,
  output logic [`XLEN-1:0]      imemAddr,
  output ifIdT                  ifId,
  output logic                  halted
);

  logic [`XLEN-1:0] pcQ;
  logic [`XLEN-1:0] pcNext;
  logic             stopFetch;

  assign imemAddr  = pcQ;
  // PC freezes from the EBREAK cycle on
  assign stopFetch = haltReq || halted;

  always_comb begin
    if (redirect.taken) begin
      pcNext = redirect.target;
    end else if (stopFetch) begin
      pcNext = pcQ;
    end else begin
      pcNext = pcQ + 4;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      pcQ        <= `PcReset;
      halted     <= 1'b0;
      ifId.valid <= 1'b0;
      ifId.pc    <= `PcReset;
      ifId.instr <= `NopInstr;
    end else begin
      pcQ     <= pcNext;
      halted  <= halted || haltReq;
      ifId.pc <= pcQ;
      // younger word is dropped on redirect or halt
      if (redirect.taken || stopFetch) begin
        ifId.valid <= 1'b0;
        ifId.instr <= `NopInstr;
      end else begin
        ifId.valid <= 1'b1;
        ifId.instr <= imemData;
      end
    end
  end

  pcAligned: assert property (@(posedge clk) disable iff (!arstN)
    imemAddr[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rtl/decoder.sv
////////////////////////////////////////////////////////////
// instruction decoder for the RV32I subset
// control bits, register indices, immediate select
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defs.svh"

module decoder
  import rvPkg::*;
(
  input  wire instrU        instr,
  output ctrlT              ctrl,
  output logic [4:0]        rs1,
  output logic [4:0]        rs2,
  output logic [4:0]        rd,
  output logic [`XLEN-1:0]  imm
);

  localparam logic [6:0] OpImm    = 7'b0010011;
  localparam logic [6:0] OpReg    = 7'b0110011;
  localparam logic [6:0] OpLui    = 7'b0110111;
  localparam logic [6:0] OpBranch = 7'b1100011;
  localparam logic [6:0] OpJal    = 7'b1101111;
  localparam logic [6:0] OpSystem = 7'b1110011;

  rTypeT            r;
  iTypeT            i;
  logic [`XLEN-1:0] iImm;
  logic [`XLEN-1:0] bImm;
  logic [`XLEN-1:0] uImm;
  logic [`XLEN-1:0] jImm;

  assign r   = instr.rType;
  assign i   = instr.iType;
  assign rs1 = r.rs1;
  assign rs2 = r.rs2;
  assign rd  = r.rd;

  // immediates rebuilt from the R-format fields
  assign iImm = {{(`XLEN-12){i.imm12[11]}}, i.imm12};
  assign bImm = {{(`XLEN-12){r.funct7[6]}}, r.rd[0], r.funct7[5:0], r.rd[4:1], 1'b0};
  assign uImm = {r.funct7, r.rs2, r.rs1, r.funct3, 12'd0};
  assign jImm = {{(`XLEN-20){r.funct7[6]}}, r.rs1, r.funct3, r.rs2[0],
                 r.funct7[5:0], r.rs2[4:1], 1'b0};

  always_comb begin
    ctrl       = '0;
    ctrl.aluOp = AluAdd;
    imm        = iImm;
    case (r.opcode)
      OpImm: begin
        // only ADDI
        ctrl.useImm  = 1'b1;
        ctrl.regWen  = (i.funct3 == 3'b000);
        ctrl.illegal = (i.funct3 != 3'b000);
      end
      OpReg: begin
        ctrl.regWen = 1'b1;
        case ({r.funct7, r.funct3})
          {7'b0000000, 3'b000}: ctrl.aluOp = AluAdd;
          {7'b0100000, 3'b000}: ctrl.aluOp = AluSub;
          {7'b0000000, 3'b111}: ctrl.aluOp = AluAnd;
          {7'b0000000, 3'b110}: ctrl.aluOp = AluOr;
          {7'b0000000, 3'b100}: ctrl.aluOp = AluXor;
          {7'b0000000, 3'b010}: ctrl.aluOp = AluSlt;
          default: begin
            ctrl.regWen  = 1'b0;
            ctrl.illegal = 1'b1;
          end
        endcase
      end
      OpLui: begin
        ctrl.aluOp  = AluPassB;
        ctrl.useImm = 1'b1;
        ctrl.regWen = 1'b1;
        ctrl.isLui  = 1'b1;
        imm         = uImm;
      end
      OpBranch: begin
        // BEQ and BNE differ only in funct3 bit 0
        ctrl.aluOp    = AluCmpEq;
        ctrl.isBranch = (r.funct3[2:1] == 2'b00);
        ctrl.branchNe = r.funct3[0];
        ctrl.illegal  = (r.funct3[2:1] != 2'b00);
        imm           = bImm;
      end
      OpJal: begin
        ctrl.regWen = 1'b1;
        ctrl.isJal  = 1'b1;
        imm         = jImm;
      end
      OpSystem: begin
        if (i.imm12 == 12'h001 && i.rs1 == 5'd0 && i.funct3 == 3'b000 && i.rd == 5'd0) begin
          ctrl.isEbreak = 1'b1;
        end else begin
          ctrl.illegal = 1'b1;
        end
      end
      default: ctrl.illegal = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/regFile.sv
////////////////////////////////////////////////////////////
// integer register file
// two combinational reads, one clocked write, x0 fixed
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defs.svh"

module regFile
  import rvPkg::*;
(
  input  wire logic             clk,
  input  wire logic             arstN,
  input  wire logic [4:0]       rs1,
  input  wire logic [4:0]       rs2,
  input  wire logic             wen,
  input  wire logic [4:0]       rd,
  input  wire logic [`XLEN-1:0] wdata,
  output logic [`XLEN-1:0]      rs1Data,
  output logic [`XLEN-1:0]      rs2Data
);

  logic [`XLEN-1:0] regs [`RegCount];

  assign rs1Data = regs[rs1];
  assign rs2Data = regs[rs2];

  // x0 is cleared at reset and never written
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int idx = 0; idx < `RegCount; idx++) begin
        regs[idx] <= '0;
      end
    end else if (wen && rd != 5'd0) begin
      regs[rd] <= wdata;
    end
  end

  x0ReadsZero: assert property (@(posedge clk) disable iff (!arstN)
    (rs1 == 5'd0 |-> rs1Data == '0) and (rs2 == 5'd0 |-> rs2Data == '0));

endmodule

`default_nettype wire

// File: rtl/executeStage.sv
////////////////////////////////////////////////////////////
// execute and write-back stage
// ID/EX register, forwarding, ALU, branch resolve, retire
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defs.svh"

module executeStage
  import rvPkg::*;
(
  input  wire logic         clk,
  input  wire logic         arstN,
  input  wire idExT         idEx,
  input  wire logic         squash,
  output logic              wen,
  output logic [4:0]        rd,
  output logic [`XLEN-1:0]  wdata,
  output logic [`XLEN-1:0]  fwdRs1,
  output logic [`XLEN-1:0]  fwdRs2,
  output redirectT          redirect,
  output logic              haltReq,
  output retireT            retire
);

  idExT             exQ;
  idExT             entryNext;
  logic [`XLEN-1:0] opB;
  logic [`XLEN-1:0] aluRes;
  logic [`XLEN-1:0] wbData;
  logic             fwdHit1;
  logic             fwdHit2;

  // write port of the regfile
  assign wen   = exQ.valid && exQ.ctrl.regWen;
  assign rd    = exQ.rd;
  assign wdata = wbData;

  // result in flight replaces the stale regfile value
  assign fwdHit1 = wen && exQ.rd != 5'd0 && exQ.rd == idEx.rs1;
  assign fwdHit2 = wen && exQ.rd != 5'd0 && exQ.rd == idEx.rs2;
  assign fwdRs1  = fwdHit1 ? wbData : idEx.rs1Data;
  assign fwdRs2  = fwdHit2 ? wbData : idEx.rs2Data;

  always_comb begin
    entryNext         = idEx;
    entryNext.rs1Data = fwdRs1;
    entryNext.rs2Data = fwdRs2;
    if (redirect.taken || haltReq || squash) begin
      entryNext.valid = 1'b0;
      entryNext.ctrl  = '0;
    end
  end

  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      exQ <= '0;
    end else begin
      exQ <= entryNext;
    end
  end

  assign opB = exQ.ctrl.useImm ? exQ.imm : exQ.rs2Data;

  always_comb begin
    case (exQ.ctrl.aluOp)
      AluAdd:   aluRes = exQ.rs1Data + opB;
      AluSub:   aluRes = exQ.rs1Data - opB;
      AluAnd:   aluRes = exQ.rs1Data & opB;
      AluOr:    aluRes = exQ.rs1Data | opB;
      AluXor:   aluRes = exQ.rs1Data ^ opB;
      AluSlt:   aluRes = {{(`XLEN-1){1'b0}}, $signed(exQ.rs1Data) < $signed(opB)};
      AluPassB: aluRes = opB;
      AluCmpEq: aluRes = {{(`XLEN-1){1'b0}}, exQ.rs1Data == opB};
      default:  aluRes = '0;
    endcase
  end

  // link address for JAL, upper immediate for LUI
  assign wbData = exQ.ctrl.isJal ? exQ.pc + 4 :
                  exQ.ctrl.isLui ? exQ.imm : aluRes;

  always_comb begin
    redirect.taken  = exQ.valid && (exQ.ctrl.isJal ||
                      (exQ.ctrl.isBranch && (aluRes[0] ^ exQ.ctrl.branchNe)));
    redirect.target = exQ.pc + exQ.imm;
  end

  assign haltReq = exQ.valid && exQ.ctrl.isEbreak;

  always_comb begin
    retire.valid   = exQ.valid;
    retire.pc      = exQ.pc;
    retire.rd      = exQ.rd;
    retire.wdata   = wbData;
    retire.wen     = wen;
    retire.illegal = exQ.valid && exQ.ctrl.illegal;
  end

  // a taken redirect leaves a bubble behind it in ID/EX
  redirectSquash: assert property (@(posedge clk) disable iff (!arstN)
    redirect.taken |-> exQ.valid ##1 !exQ.valid);

  targetAligned: assert property (@(posedge clk) disable iff (!arstN)
    redirect.taken |-> redirect.target[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: rtl/rvCore.sv
////////////////////////////////////////////////////////////
// top level of the three-stage RV32I core
// fetch port to instruction memory, retire port out
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defs.svh"

module rvCore
  import rvPkg::*;
(
  input  wire logic             clk,
  input  wire logic             arstN,
  input  wire logic [`XLEN-1:0] imemData,
  output logic [`XLEN-1:0]      imemAddr,
  output retireT                retire,
  output logic                  halted
);

  ifIdT             ifId;
  redirectT         redirect;
  logic             haltReq;
  ctrlT             decCtrl;
  logic [4:0]       decRs1;
  logic [4:0]       decRs2;
  logic [4:0]       decRd;
  logic [`XLEN-1:0] decImm;
  logic [`XLEN-1:0] rs1Data;
  logic [`XLEN-1:0] rs2Data;
  logic             wbWen;
  logic [4:0]       wbRd;
  logic [`XLEN-1:0] wbData;
  idExT             idExNext;

  fetchStage fetch_i (
    .clk      (clk),
    .arstN    (arstN),
    .imemData (imemData),
    .redirect (redirect),
    .haltReq  (haltReq),
    .imemAddr (imemAddr),
    .ifId     (ifId),
    .halted   (halted)
  );

  decoder decoder_i (
    .instr (ifId.instr),
    .ctrl  (decCtrl),
    .rs1   (decRs1),
    .rs2   (decRs2),
    .rd    (decRd),
    .imm   (decImm)
  );

  regFile regFile_i (
    .clk     (clk),
    .arstN   (arstN),
    .rs1     (decRs1),
    .rs2     (decRs2),
    .wen     (wbWen),
    .rd      (wbRd),
    .wdata   (wbData),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data)
  );

  // decode results plus raw register reads
  assign idExNext = '{valid: ifId.valid, pc: ifId.pc, ctrl: decCtrl, rd: decRd,
                      rs1: decRs1, rs2: decRs2, rs1Data: rs1Data, rs2Data: rs2Data,
                      imm: decImm};

  executeStage execute_i (
    .clk      (clk),
    .arstN    (arstN),
    .idEx     (idExNext),
    .squash   (halted),
    .wen      (wbWen),
    .rd       (wbRd),
    .wdata    (wbData),
    .fwdRs1   (),
    .fwdRs2   (),
    .redirect (redirect),
    .haltReq  (haltReq),
    .retire   (retire)
  );

endmodule

`default_nettype wire

// File: testbench/rvCoreTb.sv
////////////////////////////////////////////////////////////
// testbench for the RV32I core
// random program ROM, reference model, retire checker
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "rvCore_defs.svh"

module rvCoreTb
  import rvPkg::*;
;

  localparam int IllIdx    = 57;
  localparam int EndIdx    = 199;
  localparam int MaxCycles = 2000;

  logic             clk;
  logic             arstN;
  logic [`XLEN-1:0] imemData;
  logic [`XLEN-1:0] imemAddr;
  retireT           retire;
  logic             halted;

  logic [31:0] imem [256];
  logic [31:0] mPc;
  logic [31:0] mRegs [32];
  logic        mHalted;
  int          retireCount;
  int          illCount;
  int          errors;
  int          checks;

  rvCore rvCore_i (
    .clk      (clk),
    .arstN    (arstN),
    .imemData (imemData),
    .imemAddr (imemAddr),
    .retire   (retire),
    .halted   (halted)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  // ROM answers the PC that the last edge loaded
  always @(posedge clk) begin
    #1;
    imemData = imem[imemAddr[9:2]];
  end

  function automatic logic [31:0] rTypeWord(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] iTypeWord(input logic [11:0] imm, input logic [4:0] rs1,
                                            input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'b0010011};
  endfunction

  function automatic logic [31:0] branchWord(input int steps, input logic [4:0] rs1,
                                             input logic [4:0] rs2, input logic [2:0] f3);
    logic [12:0] off;
    off = 13'(steps * 4);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] jalWord(input int steps, input logic [4:0] rd);
    logic [20:0] off;
    off = 21'(steps * 4);
    return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
  endfunction

  // architectural step of one instruction from the ISA definition
  function automatic void refStep(input logic [31:0] pc, input logic [31:0] regs [32],
                                  input logic [31:0] word, output logic [31:0] nextPc,
                                  output logic [4:0] rd, output logic wen,
                                  output logic [31:0] wdata, output logic illegal,
                                  output logic halt);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] iImm;
    logic [31:0] bImm;
    logic [31:0] jImm;
    logic        taken;
    a       = (word[19:15] == 5'd0) ? 32'd0 : regs[word[19:15]];
    b       = (word[24:20] == 5'd0) ? 32'd0 : regs[word[24:20]];
    iImm    = {{20{word[31]}}, word[31:20]};
    bImm    = {{19{word[31]}}, word[31], word[7], word[30:25], word[11:8], 1'b0};
    jImm    = {{11{word[31]}}, word[31], word[19:12], word[20], word[30:21], 1'b0};
    nextPc  = pc + 32'd4;
    rd      = word[11:7];
    wen     = 1'b0;
    wdata   = 32'd0;
    illegal = 1'b0;
    halt    = 1'b0;
    taken   = 1'b0;
    case (word[6:0])
      7'b0010011: begin
        wen     = (word[14:12] == 3'b000);
        illegal = !wen;
        wdata   = a + iImm;
      end
      7'b0110011: begin
        wen = 1'b1;
        case ({word[31:25], word[14:12]})
          {7'h00, 3'b000}: wdata = a + b;
          {7'h20, 3'b000}: wdata = a - b;
          {7'h00, 3'b111}: wdata = a & b;
          {7'h00, 3'b110}: wdata = a | b;
          {7'h00, 3'b100}: wdata = a ^ b;
          {7'h00, 3'b010}: wdata = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          default: begin
            wen     = 1'b0;
            illegal = 1'b1;
          end
        endcase
      end
      7'b0110111: begin
        wen   = 1'b1;
        wdata = {word[31:12], 12'd0};
      end
      7'b1100011: begin
        if (word[14:12] == 3'b000) taken = (a == b);
        else if (word[14:12] == 3'b001) taken = (a != b);
        else illegal = 1'b1;
        if (taken) nextPc = pc + bImm;
      end
      7'b1101111: begin
        wen    = 1'b1;
        wdata  = pc + 32'd4;
        nextPc = pc + jImm;
      end
      7'b1110011: begin
        if (word == 32'h0010_0073) begin
          halt   = 1'b1;
          nextPc = pc;
        end else begin
          illegal = 1'b1;
        end
      end
      default: illegal = 1'b1;
    endcase
  endfunction

  task automatic checkField(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic buildProgram();
    logic [4:0] rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    int         kind;
    int         steps;
    int         limit;
    // unused words hold addi x5, x0, index
    for (int idx = 0; idx < 256; idx++) imem[idx] = iTypeWord(12'(idx), 5'd0, 3'b000, 5'd5);
    // defined start values for x1..x7
    for (int k = 0; k < 7; k++) imem[k] = iTypeWord(12'($urandom), 5'd0, 3'b000, 5'(k + 1));
    for (int k = 7; k < EndIdx; k++) begin
      kind = int'($urandom % 12);
      rd   = 5'($urandom % 8);
      rs1  = 5'($urandom % 8);
      rs2  = ($urandom % 2 == 0) ? rs1 : 5'($urandom % 8);
      // forward targets never skip the illegal word or the EBREAK
      limit = (k < IllIdx) ? IllIdx : EndIdx;
      steps = 1 + int'($urandom % 6);
      if (k + steps > limit) steps = limit - k;
      case (kind)
        0, 1, 2: imem[k] = iTypeWord(12'($urandom), rs1, 3'b000, rd);
        3: imem[k] = rTypeWord(7'h00, rs2, rs1, 3'b000, rd);
        4: imem[k] = rTypeWord(7'h20, rs2, rs1, 3'b000, rd);
        5: imem[k] = rTypeWord(7'h00, rs2, rs1, 3'b111, rd);
        6: imem[k] = rTypeWord(7'h00, rs2, rs1, 3'b110, rd);
        7: imem[k] = rTypeWord(7'h00, rs2, rs1, 3'b100, rd);
        8: imem[k] = rTypeWord(7'h00, rs2, rs1, 3'b010, rd);
        9: imem[k] = {20'($urandom), rd, 7'b0110111};
        10: imem[k] = branchWord(steps, rs1, rs2, 3'(($urandom % 2)));
        default: imem[k] = jalWord(steps, rd);
      endcase
    end
    imem[IllIdx] = 32'h0000_0000;
    imem[EndIdx] = 32'h0010_0073;
  endtask

  // architectural run of the whole program for the retire count
  task automatic expectedRetires(output int count, output int ills);
    logic [31:0] pc;
    logic [31:0] regs [32];
    logic [31:0] nextPc;
    logic [31:0] wdata;
    logic [4:0]  rd;
    logic        wen;
    logic        ill;
    logic        halt;
    pc    = 32'd0;
    count = 0;
    ills  = 0;
    for (int r = 0; r < 32; r++) regs[r] = 32'd0;
    for (int s = 0; s < 1000; s++) begin
      refStep(pc, regs, imem[pc[9:2]], nextPc, rd, wen, wdata, ill, halt);
      if (wen && rd != 5'd0) regs[rd] = wdata;
      pc = nextPc;
      count++;
      if (ill) ills++;
      if (halt) break;
    end
  endtask

  task automatic checkRetire();
    logic [31:0] nextPc;
    logic [31:0] expWdata;
    logic [4:0]  expRd;
    logic        expWen;
    logic        expIll;
    logic        expHalt;
    if (mHalted) begin
      errors++;
      $display("instruction at pc %h retired after EBREAK at %0t ns", retire.pc, $time);
      return;
    end
    refStep(mPc, mRegs, imem[mPc[9:2]], nextPc, expRd, expWen, expWdata, expIll, expHalt);
    checkField("retire.pc", retire.pc, mPc);
    checkField("retire.rd", 32'(retire.rd), 32'(expRd));
    checkField("retire.wen", 32'(retire.wen), 32'(expWen));
    checkField("retire.illegal", 32'(retire.illegal), 32'(expIll));
    if (expWen) checkField("retire.wdata", retire.wdata, expWdata);
    if (expWen && expRd != 5'd0) mRegs[expRd] = expWdata;
    mPc     = nextPc;
    mHalted = expHalt;
    retireCount++;
    if (retire.illegal) illCount++;
  endtask

  always @(posedge clk) begin
    if (arstN && retire.valid) checkRetire();
  end

  initial begin
    int          expCount;
    int          expIlls;
    int          cycles;
    logic [31:0] frozenPc;
    arstN       = 1'b0;
    imemData    = `NopInstr;
    mPc         = `PcReset;
    mHalted     = 1'b0;
    retireCount = 0;
    illCount    = 0;
    errors      = 0;
    checks      = 0;
    for (int r = 0; r < 32; r++) mRegs[r] = 32'd0;
    void'($urandom(20776));
    buildProgram();
    expectedRetires(expCount, expIlls);

    repeat (8) @(posedge clk);
    #1;
    checkField("retire.valid", 32'(retire.valid), 32'd0);
    checkField("halted", 32'(halted), 32'd0);
    checkField("imemAddr", imemAddr, `PcReset);
    arstN = 1'b1;

    cycles = 0;
    while (!halted && cycles < MaxCycles) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    if (!halted) begin
      errors++;
      $display("timeout: core did not halt within %0d cycles", MaxCycles);
    end else begin
      checkField("retire count", 32'(retireCount), 32'(expCount));
      checkField("illegal retires", 32'(illCount), 32'(expIlls));
      checkField("illegal word seen", 32'(illCount), 32'd1);
      frozenPc = imemAddr;
      // halted core keeps still and retires nothing
      for (int c = 0; c < 10; c++) begin
        @(posedge clk);
        #1;
        checkField("halted", 32'(halted), 32'd1);
        checkField("imemAddr", imemAddr, frozenPc);
      end
    end

    $display("checks %0d, errors %0d, retired %0d", checks, errors, retireCount);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: rvCore.f
+incdir+rtl
rtl/rvPkg.sv
rtl/fetchStage.sv
rtl/decoder.sv
rtl/regFile.sv
rtl/executeStage.sv
rtl/rvCore.sv
testbench/rvCoreTb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f rvCore.f --top-module rvCoreTb -o rvCoreSim

out="$(./obj_dir/rvCoreSim 2>&1)" || true
echo "$out"

grep -q "SIMULATION PASSED" <<< "$out"
